// ==== design/bsum_defs.svh ====
// =========================================================
// shared width and depth macros for the byte-sum engine.
// =========================================================

`ifndef BSUM_DEFS_SVH
`define BSUM_DEFS_SVH

// one data beat and its byte strobe.
`define BSUM_DATA_WIDTH 32
`define BSUM_STRB_WIDTH 4

// slots in the early-stall FIFO.
`define BSUM_FIFO_DEPTH 8

// packet tag carried on the side channel.
`define BSUM_TAG_WIDTH 4

// 64 full beats of 4 bytes stay below 2**16.
`define BSUM_SUM_WIDTH 16

`endif

// ==== design/bsum_pkg.sv ====
// =========================================================
// types shared by the FIFO, the accumulator and the top.
// =========================================================

package bsum_pkg;

  `include "bsum_defs.svh"

  // side channel that travels with every beat.
  typedef struct packed {
    logic                       last; // closes the packet.
    logic [`BSUM_TAG_WIDTH-1:0] tag;  // packet tag.
  } sidech_t;

  // only the empty flag is exported.
  typedef struct packed {
    logic empty;
  } flags_fifo_t;

  // packet byte sum.
  typedef logic [`BSUM_SUM_WIDTH-1:0] sum_t;

endpackage

// ==== design/bsum_stream_intf.sv ====
// =========================================================
// valid/ready stream of data beats with a byte strobe.
// =========================================================

`include "bsum_defs.svh"

interface bsum_stream_intf;

  logic                        valid; // driven by the source.
  logic                        ready; // driven by the sink.
  logic [`BSUM_DATA_WIDTH-1:0] data;
  logic [`BSUM_STRB_WIDTH-1:0] strb;

  modport source (
    output valid, data, strb,
    input  ready
  );

  modport sink (
    input  valid, data, strb,
    output ready
  );

  // passive view for checkers.
  modport monitor (
    input valid, ready, data, strb
  );

endinterface

// ==== design/bsum_fifo_earlystall.sv ====
// =========================================================
// circular FIFO with early stall and a typed side channel.
// =========================================================

`include "bsum_defs.svh"

module bsum_fifo_earlystall
  import bsum_pkg::*;
#(
  parameter type         SIDECH_T = sidech_t,
  parameter int unsigned DEPTH    = `BSUM_FIFO_DEPTH
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,

  bsum_stream_intf.sink   push_i,
  bsum_stream_intf.source pop_o,

  input  SIDECH_T     sidech_i,
  output SIDECH_T     sidech_o,
  output flags_fifo_t flags_o
);

  localparam int unsigned ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef enum logic [1:0] {
    EMPTY,
    MIDDLE,
    FULL
  } state_e;

  // one slot keeps side channel, data and strobe together.
  typedef struct packed {
    SIDECH_T                     sidech;
    logic [`BSUM_DATA_WIDTH-1:0] data;
    logic [`BSUM_STRB_WIDTH-1:0] strb;
  } entry_t;

  state_e              cs_q, ns_d;
  logic [ADDR_W-1:0]   push_ptr_q, push_ptr_d;
  logic [ADDR_W-1:0]   pop_ptr_q, pop_ptr_d;
  logic [ADDR_W-1:0]   push_ptr_inc, pop_ptr_inc;
  logic [ADDR_W:0]     fill_cnt;
  logic                push_en, pop_en;
  entry_t              mem_q [DEPTH];
  entry_t              rd_entry;

  // wrap at DEPTH-1 so non power-of-two depths work too.
  function automatic logic [ADDR_W-1:0] ptr_inc(input logic [ADDR_W-1:0] ptr);
    if (ptr == ADDR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ptr_inc = ptr_inc(push_ptr_q);
  assign pop_ptr_inc  = ptr_inc(pop_ptr_q);

  // a late valid still lands as long as a slot is free.
  assign push_en = push_i.valid && (cs_q != FULL);
  assign pop_en  = pop_o.valid && pop_o.ready;

  assign push_ptr_d = push_en ? push_ptr_inc : push_ptr_q;
  assign pop_ptr_d  = pop_en ? pop_ptr_inc : pop_ptr_q;

  // occupied slots, meaningful in MIDDLE only.
  always_comb begin
    if (push_ptr_q >= pop_ptr_q) begin
      fill_cnt = {1'b0, push_ptr_q} - {1'b0, pop_ptr_q};
    end else begin
      fill_cnt = (ADDR_W + 1)'(DEPTH) + {1'b0, push_ptr_q} - {1'b0, pop_ptr_q};
    end
  end

  always_comb begin
    ns_d         = cs_q;
    push_i.ready = 1'b0;
    pop_o.valid  = 1'b0;
    case (cs_q)
      EMPTY: begin
        push_i.ready = 1'b1;
        if (push_en) begin
          ns_d = MIDDLE;
        end
      end
      MIDDLE: begin
        // stall while two or fewer slots are free.
        push_i.ready = (fill_cnt < (ADDR_W + 1)'(DEPTH - 2));
        pop_o.valid  = 1'b1;
        if (push_en && !pop_en && (push_ptr_inc == pop_ptr_q)) begin
          ns_d = FULL; // last slot taken.
        end else if (pop_en && !push_en && (pop_ptr_inc == push_ptr_q)) begin
          ns_d = EMPTY; // last beat leaves.
        end
      end
      FULL: begin
        pop_o.valid = 1'b1;
        if (pop_en) begin
          ns_d = MIDDLE;
        end
      end
      default: begin
        ns_d = EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs_q       <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else if (clear_i) begin
      cs_q       <= EMPTY;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else begin
      cs_q       <= ns_d;
      push_ptr_q <= push_ptr_d;
      pop_ptr_q  <= pop_ptr_d;
    end
  end

  // flop storage, zeroed on reset and clear.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < DEPTH; s++) begin
        mem_q[s] <= '0;
      end
    end else if (clear_i) begin
      for (int s = 0; s < DEPTH; s++) begin
        mem_q[s] <= '0;
      end
    end else if (push_en) begin
      mem_q[push_ptr_q] <= '{sidech: sidech_i, data: push_i.data, strb: push_i.strb};
    end
  end

  // head slot falls through to the pop port.
  assign rd_entry = mem_q[pop_ptr_q];

  assign pop_o.data = pop_o.valid ? rd_entry.data : '0;
  assign pop_o.strb = pop_o.valid ? rd_entry.strb : '0;
  assign sidech_o   = pop_o.valid ? rd_entry.sidech : '0;

  assign flags_o.empty = (cs_q == EMPTY);

endmodule

// ==== design/bsum_packet_accum.sv ====
// =========================================================
// per-packet sum of strobe-enabled bytes, held until taken.
// =========================================================

`include "bsum_defs.svh"

module bsum_packet_accum
  import bsum_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,

  bsum_stream_intf.sink              beat_i,
  input  sidech_t                    sidech_i,

  input  logic                       result_ready_i,
  output logic                       result_valid_o,
  output sum_t                       sum_o,
  output logic [`BSUM_TAG_WIDTH-1:0] tag_o
);

  sum_t                       running_q;
  sum_t                       beat_sum;
  sum_t                       sum_q;
  logic [`BSUM_TAG_WIDTH-1:0] tag_q;
  logic                       result_valid_q;
  logic                       beat_fire;
  logic                       last_fire;

  // no new beat while a result waits.
  assign beat_i.ready = !result_valid_q;

  assign beat_fire = beat_i.valid && beat_i.ready;
  assign last_fire = beat_fire && sidech_i.last;

  // bytes of the current beat with their strobe set.
  always_comb begin
    beat_sum = '0;
    for (int b = 0; b < `BSUM_STRB_WIDTH; b++) begin
      if (beat_i.strb[b]) begin
        beat_sum = beat_sum + sum_t'(beat_i.data[8*b +: 8]);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q      <= '0;
      result_valid_q <= 1'b0;
    end else if (clear_i) begin
      running_q      <= '0; // partial packet dropped.
      result_valid_q <= 1'b0;
    end else begin
      if (last_fire) begin
        running_q <= '0; // next packet starts fresh.
      end else if (beat_fire) begin
        running_q <= running_q + beat_sum;
      end

      if (last_fire) begin
        result_valid_q <= 1'b1;
      end else if (result_ready_i) begin
        result_valid_q <= 1'b0; // result taken.
      end
    end
  end

  // result payload, loaded with the last beat.
  always_ff @(posedge clk_i) begin
    if (last_fire) begin
      sum_q <= running_q + beat_sum;
      tag_q <= sidech_i.tag;
    end
  end

  assign result_valid_o = result_valid_q;
  assign sum_o          = sum_q;
  assign tag_o          = tag_q;

endmodule

// ==== design/bsum_top.sv ====
// =========================================================
// byte-sum engine top: early-stall FIFO feeding the
// packet accumulator.
// =========================================================

`include "bsum_defs.svh"

module bsum_top
  import bsum_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,

  // input stream.
  input  logic                        in_valid_i,
  input  logic [`BSUM_DATA_WIDTH-1:0] in_data_i,
  input  logic [`BSUM_STRB_WIDTH-1:0] in_strb_i,
  input  logic                        in_last_i,
  input  logic [`BSUM_TAG_WIDTH-1:0]  in_tag_i,
  output logic                        push_ready_o,
  output logic                        fifo_empty_o,

  // packet result.
  output logic                        result_valid_o,
  input  logic                        result_ready_i,
  output sum_t                        sum_o,
  output logic [`BSUM_TAG_WIDTH-1:0]  tag_o
);

  bsum_stream_intf in_s ();
  bsum_stream_intf fifo_s ();

  sidech_t     in_sidech;
  sidech_t     fifo_sidech;
  flags_fifo_t fifo_flags;

  assign in_s.valid   = in_valid_i;
  assign in_s.data    = in_data_i;
  assign in_s.strb    = in_strb_i;
  assign push_ready_o = in_s.ready; // early-stall ready.

  assign in_sidech.last = in_last_i;
  assign in_sidech.tag  = in_tag_i;

  assign fifo_empty_o = fifo_flags.empty;

  bsum_fifo_earlystall #(
    .SIDECH_T ( sidech_t         ),
    .DEPTH    ( `BSUM_FIFO_DEPTH )
  ) u_fifo (
    .clk_i    ( clk_i       ),
    .rst_ni   ( rst_ni      ),
    .clear_i  ( clear_i     ),
    .push_i   ( in_s        ),
    .pop_o    ( fifo_s      ),
    .sidech_i ( in_sidech   ),
    .sidech_o ( fifo_sidech ),
    .flags_o  ( fifo_flags  )
  );

  bsum_packet_accum u_accum (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .beat_i         ( fifo_s         ),
    .sidech_i       ( fifo_sidech    ),
    .result_ready_i ( result_ready_i ),
    .result_valid_o ( result_valid_o ),
    .sum_o          ( sum_o          ),
    .tag_o          ( tag_o          )
  );

endmodule

// ==== test/bsum_asserts.sv ====
// ============================================================
// port checker for the byte-sum top: packet model in a queue
// and concurrent assertions for sums, hold, stall and flags.
// ============================================================

`include "bsum_defs.svh"

module bsum_asserts
  import bsum_pkg::*;
(
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        clear_i,
  input logic                        in_valid_i,
  input logic [`BSUM_DATA_WIDTH-1:0] in_data_i,
  input logic [`BSUM_STRB_WIDTH-1:0] in_strb_i,
  input logic                        in_last_i,
  input logic [`BSUM_TAG_WIDTH-1:0]  in_tag_i,
  input logic                        push_ready_o,
  input logic                        fifo_empty_o,
  input logic                        result_valid_o,
  input logic                        result_ready_i,
  input sum_t                        sum_o,
  input logic [`BSUM_TAG_WIDTH-1:0]  tag_o
);

  typedef struct packed {
    sum_t                       sum;
    logic [`BSUM_TAG_WIDTH-1:0] tag;
    logic [7:0]                 beats; // beats in the packet.
  } result_t;

  result_t                    model_q [$];
  sum_t                       run_sum_q;
  logic [7:0]                 run_beats_q;
  sum_t                       exp_sum_q;
  logic [`BSUM_TAG_WIDTH-1:0] exp_tag_q;
  int                         exp_cnt;
  int                         open_beats;   // accepted beats whose result is not yet taken.
  int                         stall_cnt;    // beats accepted while a result is held.
  int                         err_cnt = 0;
  logic                       post_rst_q, clr_q, hold_q;
  logic [1:0]                 idle_q;
  sum_t                       held_sum_q;
  logic [`BSUM_TAG_WIDTH-1:0] held_tag_q;

  // enabled bytes of one beat.
  function automatic sum_t byte_sum(input logic [31:0] data, input logic [3:0] strb);
    sum_t acc;
    acc = '0;
    for (int b = 0; b < `BSUM_STRB_WIDTH; b++) begin
      if (strb[b]) begin
        acc = acc + sum_t'((data >> (8 * b)) & 32'hff);
      end
    end
    return acc;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin : model_p
    sum_t    beat_sum;
    result_t entry;
    int      beats_left;
    if (!rst_ni || clear_i) begin
      model_q.delete();
      run_sum_q   <= '0;
      run_beats_q <= '0;
      exp_cnt     <= 0;
      open_beats  <= 0;
    end else begin
      beats_left = open_beats;
      if (result_valid_o && result_ready_i && model_q.size() != 0) begin
        beats_left = beats_left - int'(model_q[0].beats);
        void'(model_q.pop_front());
      end
      if (in_valid_i) begin
        beat_sum   = byte_sum(in_data_i, in_strb_i);
        beats_left = beats_left + 1;
        if (in_last_i) begin
          entry.sum   = run_sum_q + beat_sum;
          entry.tag   = in_tag_i;
          entry.beats = run_beats_q + 8'd1;
          model_q.push_back(entry);
          run_sum_q   <= '0;
          run_beats_q <= '0;
        end else begin
          run_sum_q   <= run_sum_q + beat_sum;
          run_beats_q <= run_beats_q + 8'd1;
        end
      end
      open_beats <= beats_left;
      exp_cnt    <= model_q.size();
      if (model_q.size() != 0) begin
        exp_sum_q <= model_q[0].sum;
        exp_tag_q <= model_q[0].tag;
      end
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin : track_p
    if (!rst_ni) begin
      post_rst_q <= 1'b1;
      clr_q      <= 1'b0;
      hold_q     <= 1'b0;
      idle_q     <= 2'b00;
      stall_cnt  <= 0;
    end else begin
      post_rst_q <= 1'b0;
      clr_q      <= clear_i;
      idle_q     <= {idle_q[0], !in_valid_i};
      hold_q     <= result_valid_o && !result_ready_i && !clear_i;
      held_sum_q <= sum_o;
      held_tag_q <= tag_o;
      if (clear_i || !result_valid_o || result_ready_i) begin
        stall_cnt <= 0;
      end else if (in_valid_i) begin
        stall_cnt <= stall_cnt + 1; // no pop while the result waits.
      end
    end
  end

  a_result_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o |-> exp_cnt != 0)
    else begin
      err_cnt <= err_cnt + 1;
      $error("** Error at %0t: result_valid_o expected 0, got 1", $time);
    end

  a_sum: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && result_ready_i |-> sum_o == exp_sum_q)
    else begin
      err_cnt <= err_cnt + 1;
      $error("** Error at %0t: sum_o expected %0h, got %0h", $time, exp_sum_q, sum_o);
    end

  a_tag: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && result_ready_i |-> tag_o == exp_tag_q)
    else begin
      err_cnt <= err_cnt + 1;
      $error("** Error at %0t: tag_o expected %0h, got %0h", $time, exp_tag_q, tag_o);
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hold_q |-> result_valid_o && sum_o == held_sum_q && tag_o == held_tag_q)
    else begin
      err_cnt <= err_cnt + 1;
      $error("** Error at %0t: held sum_o/tag_o expected %0h/%0h, got %0h/%0h valid %b",
             $time, held_sum_q, held_tag_q, sum_o, tag_o, result_valid_o);
    end

  a_early_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_cnt >= `BSUM_FIFO_DEPTH - 2 |-> !push_ready_o)
    else begin
      err_cnt <= err_cnt + 1;
      $error("** Error at %0t: push_ready_o expected 0, got 1", $time);
    end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_cnt < `BSUM_FIFO_DEPTH)
    else begin
      err_cnt <= err_cnt + 1;
      $error("FIFO took %0d beats while a result was held, more than it holds", stall_cnt);
    end

  a_after_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    post_rst_q || clr_q |-> push_ready_o && fifo_empty_o && !result_valid_o)
    else begin
      err_cnt <= err_cnt + 1;
      $error(
        "** Error at %0t: push_ready_o/fifo_empty_o/result_valid_o expected 1/1/0, got %b/%b/%b",
        $time, push_ready_o, fifo_empty_o, result_valid_o);
    end

  a_empty_flag: assert property (@(posedge clk_i) disable iff (!rst_ni)
    open_beats == 0 && idle_q == 2'b11 |-> fifo_empty_o)
    else begin
      err_cnt <= err_cnt + 1;
      $error("** Error at %0t: fifo_empty_o expected 1, got 0", $time);
    end

endmodule

bind bsum_top bsum_asserts u_asserts (.*);

// ==== test/bsum_tb.sv ====
// ============================================================
// testbench for the byte-sum engine: clock, reset, random
// packet traffic with back-pressure, clear and final drain.
// ============================================================

`include "bsum_defs.svh"

module bsum_tb;

  localparam logic [31:0] SEED    = 32'd49130;
  localparam int          TIMEOUT = 200;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        clear_i;
  logic                        in_valid_i;
  logic [`BSUM_DATA_WIDTH-1:0] in_data_i;
  logic [`BSUM_STRB_WIDTH-1:0] in_strb_i;
  logic                        in_last_i;
  logic [`BSUM_TAG_WIDTH-1:0]  in_tag_i;
  logic                        push_ready_o;
  logic                        fifo_empty_o;
  logic                        result_valid_o;
  logic                        result_ready_i;
  logic [`BSUM_SUM_WIDTH-1:0]  sum_o;
  logic [`BSUM_TAG_WIDTH-1:0]  tag_o;

  logic [31:0] stim_rng;
  logic [31:0] rdy_rng;
  int          cyc       = 0;
  int          hold_end  = 0;  // result ready forced low before this cycle.
  int          ready_pct = 70;

  bsum_top DUT (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  // result ready pattern, own random stream.
  always @(posedge clk_i) begin : ready_drive
    logic [31:0] r;
    rdy_rng = xorshift(rdy_rng);
    r       = rdy_rng;
    if (cyc < hold_end) begin
      result_ready_i <= 1'b0;
    end else begin
      result_ready_i <= (r % 100) < ready_pct;
    end
  end

  // stop at the first failed assertion.
  always @(negedge clk_i) begin
    if (DUT.u_asserts.err_cnt != 0) begin
      $display("Simulation FAILED");
      $fatal(1, "assertion check failed");
    end
  end

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s at time %0t", what, $time);
    $display("Simulation FAILED");
    $fatal(1, "wait limit reached");
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      in_valid_i <= 1'b0;
      in_last_i  <= 1'b0;
    end
  endtask

  // valid follows the push ready seen at the previous edge.
  task automatic send_packet(input int len, input bit close, input int idle_pct);
    logic [31:0] r;
    logic [3:0]  tag;
    int          waited;
    r   = next_rand();
    tag = r[3:0];
    for (int i = 0; i < len; i++) begin
      waited = 0;
      @(posedge clk_i);
      r = next_rand();
      while (!push_ready_o || (r % 100) < idle_pct) begin
        in_valid_i <= 1'b0;
        waited++;
        if (waited > TIMEOUT) begin
          fail_timeout("push_ready_o");
        end
        @(posedge clk_i);
        r = next_rand();
      end
      in_valid_i <= 1'b1;
      in_last_i  <= close && (i == len - 1);
      in_tag_i   <= tag;
      r = next_rand();
      in_data_i  <= r;
      r = next_rand();
      in_strb_i  <= r[3:0];
    end
  endtask

  task automatic random_packets(input int count, input int idle_pct);
    logic [31:0] r;
    for (int p = 0; p < count; p++) begin
      r = next_rand();
      send_packet(1 + int'(r % 6), 1'b1, idle_pct);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    idle_cycles(2);
    while (DUT.u_asserts.open_beats != 0 || result_valid_o) begin
      @(posedge clk_i);
      waited++;
      if (waited > 4 * TIMEOUT) begin
        fail_timeout("the last result to drain");
      end
    end
  endtask

  task automatic pulse_clear();
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    clear_i    <= 1'b1;
    @(posedge clk_i);
    clear_i    <= 1'b0;
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    in_valid_i     = 1'b0;
    in_data_i      = '0;
    in_strb_i      = '0;
    in_last_i      = 1'b0;
    in_tag_i       = '0;
    result_ready_i = 1'b0;
    stim_rng       = SEED;
    rdy_rng        = xorshift(SEED);
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    idle_cycles(2);

    random_packets(12, 25);
    wait_drain();
    idle_cycles(3);

    hold_end <= cyc + 40; // long enough to fill the FIFO.
    random_packets(8, 0);
    wait_drain();
    idle_cycles(3);

    // pending result and half packet, both dropped by clear.
    ready_pct <= 0;
    send_packet(3, 1'b1, 0);
    send_packet(4, 1'b0, 0);
    pulse_clear();
    ready_pct <= 70;
    idle_cycles(2);

    random_packets(10, 15);
    wait_drain();
    idle_cycles(3);

    if (DUT.u_asserts.err_cnt == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "assertion check failed");
    end
  end

endmodule

// ==== all.f ====
+incdir+design
design/bsum_pkg.sv
design/bsum_stream_intf.sv
design/bsum_fifo_earlystall.sv
design/bsum_packet_accum.sv
design/bsum_top.sv
test/bsum_asserts.sv
test/bsum_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the byte-sum testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module bsum_tb -f all.f

# assertion errors do not stop the run, so the testbench can report them itself.
out=$(./obj_dir/Vbsum_tb +verilator+error+limit+100 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1
